// ==== rtl/cpu_pkg.sv ====
// widths, memory depth, opcode and bus source enums, control word and load word structs
package cpu_pkg;

    // datapath and address widths fixed by the instruction format
    localparam int data_width = 8;
    localparam int addr_width = 4;
    localparam int mem_depth  = 16;

    // high nibble of an instruction byte
    // codes not listed here decode as NOP
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDA = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        STA = 4'd4,
        LDI = 4'd5,
        JMP = 4'd6,
        JC  = 4'd7,
        JZ  = 4'd8,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // which block drives the shared bus this cycle
    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_RAM,
        BUS_OPERAND,
        BUS_ACC,
        BUS_ALU
    } bus_src_e;

    // one cycle of control, all strobes active high
    typedef struct packed {
        bus_src_e bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     pc_clear;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     acc_load;
        logic     b_load;
        logic     alu_sub;
        logic     flags_load;
        logic     out_load;
        // only in idle
        logic     load_allow;
    } ctrl_word_t;

    // one program byte on the load port
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } load_word_t;

endpackage

// ==== rtl/control_block.sv ====
// run/halt FSM and T-state microsequencer decoding the opcode into a control word
`timescale 1ns/1ps

module control_block (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  cpu_pkg::opcode_e    opcode,
    input  logic                carry_flag,
    input  logic                zero_flag,
    input  logic                out_busy,
    output cpu_pkg::ctrl_word_t ctrl,
    output logic                halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        state_idle,
        state_t0,
        state_t1,
        state_t2,
        state_t3,
        state_t4,
        state_halt
    } state_e;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    // sequencing, five cycles per instruction
    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (run) begin
                    state_next = state_t0;
                end
            end
            state_t0: state_next = state_t1;
            state_t1: state_next = state_t2;
            state_t2: begin
                if (opcode == HLT) begin
                    state_next = state_halt;
                end else if (opcode == OUT && out_busy) begin
                    // hold here until the last value was taken
                    state_next = state_t2;
                end else begin
                    state_next = state_t3;
                end
            end
            state_t3: state_next = state_t4;
            state_t4: state_next = state_t0;
            state_halt: begin
                if (!run) begin
                    state_next = state_idle;
                end
            end
            default: state_next = state_idle;
        endcase
    end

    // control word decode from state and opcode
    always_comb begin
        ctrl = '0;
        ctrl.bus_src = BUS_NONE;
        case (state)
            state_idle: begin
                ctrl.load_allow = 1'b1;
                // pc back to zero as the run starts
                ctrl.pc_clear = run;
            end
            // fetch
            state_t0: begin
                ctrl.bus_src = BUS_PC;
                ctrl.mar_load = 1'b1;
            end
            state_t1: begin
                ctrl.bus_src = BUS_RAM;
                ctrl.ir_load = 1'b1;
                ctrl.pc_inc = 1'b1;
            end
            // execute
            state_t2: begin
                case (opcode)
                    LDA, ADD, SUB, STA: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.mar_load = 1'b1;
                    end
                    LDI: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.acc_load = 1'b1;
                    end
                    JMP, JC, JZ: begin
                        ctrl.bus_src = BUS_OPERAND;
                        ctrl.pc_load = (opcode == JMP) ||
                                       (opcode == JC && carry_flag) ||
                                       (opcode == JZ && zero_flag);
                    end
                    OUT: begin
                        if (!out_busy) begin
                            ctrl.bus_src = BUS_ACC;
                            ctrl.out_load = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            state_t3: begin
                case (opcode)
                    LDA: begin
                        ctrl.bus_src = BUS_RAM;
                        ctrl.acc_load = 1'b1;
                    end
                    ADD, SUB: begin
                        ctrl.bus_src = BUS_RAM;
                        ctrl.b_load = 1'b1;
                    end
                    STA: begin
                        ctrl.bus_src = BUS_ACC;
                        ctrl.ram_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            state_t4: begin
                if (opcode == ADD || opcode == SUB) begin
                    ctrl.bus_src = BUS_ALU;
                    ctrl.alu_sub = (opcode == SUB);
                    ctrl.acc_load = 1'b1;
                    ctrl.flags_load = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign halted = (state == state_halt);

endmodule

// ==== rtl/program_counter.sv ====
// four-bit program counter with increment, jump load and clear
`timescale 1ns/1ps

module program_counter (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_word_t            ctrl,
    input  logic [cpu_pkg::data_width-1:0] bus_value,
    output logic [cpu_pkg::addr_width-1:0] pc
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || ctrl.pc_clear) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            // jump target is the low nibble
            pc <= bus_value[addr_width-1:0];
        end else if (ctrl.pc_inc) begin
            // wraps at sixteen
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== rtl/alu.sv ====
// adder/subtractor of accumulator and B with carry and zero flag registers
`timescale 1ns/1ps

module alu (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_word_t            ctrl,
    input  logic [cpu_pkg::data_width-1:0] acc,
    input  logic [cpu_pkg::data_width-1:0] b,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           carry_flag,
    output logic                           zero_flag
);
    import cpu_pkg::*;

    logic [data_width-1:0] b_operand;
    logic [data_width:0]   sum_ext;

    // two's complement subtract, invert b and carry in one
    assign b_operand = ctrl.alu_sub ? ~b : b;
    assign sum_ext = {1'b0, acc} + {1'b0, b_operand} + {{data_width{1'b0}}, ctrl.alu_sub};
    assign result = sum_ext[data_width-1:0];

    // flags only move on add/sub write-back
    always_ff @(posedge clk) begin
        if (reset) begin
            carry_flag <= 1'b0;
            zero_flag <= 1'b0;
        end else if (ctrl.flags_load) begin
            carry_flag <= sum_ext[data_width];
            zero_flag <= (result == '0);
        end
    end

endmodule

// ==== rtl/program_memory.sv ====
// memory address register, sixteen-byte RAM, bus write path and four-phase load port
`timescale 1ns/1ps

module program_memory (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_word_t            ctrl,
    input  logic [cpu_pkg::data_width-1:0] bus_value,
    input  logic                           load_req,
    input  cpu_pkg::load_word_t            load_word,
    output logic                           load_ack,
    output logic [cpu_pkg::data_width-1:0] ram_data
);
    import cpu_pkg::*;

    logic [addr_width-1:0] mar;
    logic [data_width-1:0] mem [mem_depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus_value[addr_width-1:0];
        end
    end

    // program stores and host loads never overlap
    // load_allow is idle only, ram_write is T3 only
    always_ff @(posedge clk) begin
        if (ctrl.ram_write) begin
            mem[mar] <= bus_value;
        end else if (ctrl.load_allow && load_req && !load_ack) begin
            mem[load_word.addr] <= load_word.data;
        end
    end

    // four-phase ack
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ack <= 1'b0;
        end else if (ctrl.load_allow && load_req && !load_ack) begin
            load_ack <= 1'b1;
        end else if (load_ack && !load_req) begin
            load_ack <= 1'b0;
        end
    end

    // asynchronous read at the MAR
    assign ram_data = mem[mar];

endmodule

// ==== rtl/bus_registers.sv ====
// bus multiplexer, accumulator, B register and instruction register
`timescale 1ns/1ps

module bus_registers (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_word_t            ctrl,
    input  logic [cpu_pkg::addr_width-1:0] pc,
    input  logic [cpu_pkg::data_width-1:0] ram_data,
    input  logic [cpu_pkg::data_width-1:0] alu_result,
    output logic [cpu_pkg::data_width-1:0] bus_value,
    output logic [cpu_pkg::data_width-1:0] acc,
    output logic [cpu_pkg::data_width-1:0] b,
    output cpu_pkg::opcode_e               opcode
);
    import cpu_pkg::*;

    logic [data_width-1:0] ir;
    logic [addr_width-1:0] operand;

    // ir split, high nibble opcode, low nibble operand
    assign opcode = opcode_e'(ir[data_width-1:addr_width]);
    assign operand = ir[addr_width-1:0];

    // one driver per cycle, nothing selected reads zero
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:      bus_value = {{(data_width - addr_width){1'b0}}, pc};
            BUS_RAM:     bus_value = ram_data;
            BUS_OPERAND: bus_value = {{(data_width - addr_width){1'b0}}, operand};
            BUS_ACC:     bus_value = acc;
            BUS_ALU:     bus_value = alu_result;
            default:     bus_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            b <= '0;
            ir <= '0;
        end else begin
            if (ctrl.acc_load) begin
                acc <= bus_value;
            end
            if (ctrl.b_load) begin
                b <= bus_value;
            end
            if (ctrl.ir_load) begin
                ir <= bus_value;
            end
        end
    end

endmodule

// ==== rtl/output_port.sv ====
// output register with four-phase req/ack handshake and busy status
`timescale 1ns/1ps

module output_port (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_pkg::ctrl_word_t            ctrl,
    input  logic [cpu_pkg::data_width-1:0] bus_value,
    input  logic                           out_ack,
    output logic                           out_req,
    output logic [cpu_pkg::data_width-1:0] out_value,
    output logic                           out_busy
);

    // value held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (ctrl.out_load) begin
            out_value <= bus_value;
        end
    end

    // out_load is only issued while not busy
    always_ff @(posedge clk) begin
        if (reset) begin
            out_req <= 1'b0;
            out_busy <= 1'b0;
        end else if (ctrl.out_load) begin
            out_req <= 1'b1;
            out_busy <= 1'b1;
        end else begin
            // req drops once the host acks
            if (out_req && out_ack) begin
                out_req <= 1'b0;
            end
            // free again after the ack has fallen
            if (out_busy && !out_req && !out_ack) begin
                out_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/cpu_top.sv ====
// top level of the accumulator CPU, datapath blocks and control wiring
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           run,
    input  logic                           load_req,
    input  cpu_pkg::load_word_t            load_word,
    output logic                           load_ack,
    output logic                           out_req,
    output logic [cpu_pkg::data_width-1:0] out_value,
    input  logic                           out_ack,
    output logic                           halted
);
    import cpu_pkg::*;

    ctrl_word_t            ctrl;
    opcode_e               opcode;
    logic [data_width-1:0] bus_value;
    logic [data_width-1:0] ram_data;
    logic [data_width-1:0] alu_result;
    logic [data_width-1:0] acc;
    logic [data_width-1:0] b;
    logic [addr_width-1:0] pc;
    logic                  carry_flag;
    logic                  zero_flag;
    logic                  out_busy;

    // sequencer
    control_block control_block_i (
        .clk(clk),
        .reset(reset),
        .run(run),
        .opcode(opcode),
        .carry_flag(carry_flag),
        .zero_flag(zero_flag),
        .out_busy(out_busy),
        .ctrl(ctrl),
        .halted(halted)
    );

    program_counter program_counter_i (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .bus_value(bus_value),
        .pc(pc)
    );

    alu alu_i (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .acc(acc),
        .b(b),
        .result(alu_result),
        .carry_flag(carry_flag),
        .zero_flag(zero_flag)
    );

    // mar, ram and host load port
    program_memory program_memory_i (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .bus_value(bus_value),
        .load_req(load_req),
        .load_word(load_word),
        .load_ack(load_ack),
        .ram_data(ram_data)
    );

    // bus owner
    bus_registers bus_registers_i (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .pc(pc),
        .ram_data(ram_data),
        .alu_result(alu_result),
        .bus_value(bus_value),
        .acc(acc),
        .b(b),
        .opcode(opcode)
    );

    output_port output_port_i (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .bus_value(bus_value),
        .out_ack(out_ack),
        .out_req(out_req),
        .out_value(out_value),
        .out_busy(out_busy)
    );

endmodule

// ==== testbench/cpu_assertions.sv ====
// handshake assertions bound into the CPU top level
`timescale 1ns/1ps

module cpu_assertions (
    input logic                           clk,
    input logic                           reset,
    input logic                           load_req,
    input logic                           load_ack,
    input logic                           out_req,
    input logic [cpu_pkg::data_width-1:0] out_value
);

    // value held for as long as the request is up
    out_value_stable: assert property (@(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(out_value))
        else $error("out_value changed while out_req was high");

    // ack only answers a request
    load_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(load_ack) |-> $past(load_req))
        else $error("load_ack rose without load_req");

    out_req_low_after_reset: assert property (@(posedge clk)
        reset |=> !out_req)
        else $error("out_req high in the cycle after reset");

endmodule

// ==== testbench/cpu_checker.sv ====
// monitor of the output port and halt, compares values with the expected list per test
`timescale 1ns/1ps

module cpu_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           out_req,
    input  logic                           out_ack,
    input  logic [cpu_pkg::data_width-1:0] out_value,
    input  logic                           halted,
    input  int                             test_index,
    input  logic [31:0]                    expected,
    input  int                             exp_count,
    output int                             pass_count,
    output int                             fail_count,
    output int                             report_count
);
    import cpu_pkg::*;

    int                    seen;
    int                    errors;
    logic [data_width-1:0] exp_value;
    // one verdict per halt, cleared once halted falls
    logic                  reported;

    always @(posedge clk) begin
        if (reset) begin
            seen = 0;
            errors = 0;
            pass_count = 0;
            fail_count = 0;
            report_count = 0;
            reported = 1'b0;
        end else begin
            if (!halted) begin
                reported = 1'b0;
            end
            // req and ack both high for exactly one edge per value
            if (out_req && out_ack) begin
                if (seen >= exp_count) begin
                    $display("** Error: %0t test %0d extra output %02h",
                             $time, test_index, out_value);
                    errors++;
                end else begin
                    exp_value = expected[31 - 8 * seen -: 8];
                    if (out_value !== exp_value) begin
                        $display("** Error: %0t test %0d output %0d got %02h expected %02h",
                                 $time, test_index, seen, out_value, exp_value);
                        errors++;
                    end
                end
                seen++;
            end
            // verdict once halted and the port has gone quiet
            if (halted && !reported && !out_req && !out_ack) begin
                if (seen != exp_count) begin
                    $display("** Error: %0t test %0d gave %0d outputs, expected %0d",
                             $time, test_index, seen, exp_count);
                    errors++;
                end
                if (errors == 0) begin
                    pass_count++;
                    $display("test %0d passed with %0d outputs", test_index, seen);
                end else begin
                    fail_count++;
                    $display("test %0d failed with %0d errors", test_index, errors);
                end
                report_count++;
                reported = 1'b1;
                seen = 0;
                errors = 0;
            end
        end
    end

endmodule

// ==== testbench/cpu_tb.sv ====
// testbench top with clock, reset, program table, load and run loop, ack responder and verdict
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int n_tests = 7;
    localparam int timeout_cycles = 2000;

    logic                  clk;
    logic                  reset;
    logic                  run;
    logic                  load_req;
    load_word_t            load_word;
    logic                  load_ack;
    logic                  out_req;
    logic [data_width-1:0] out_value;
    logic                  out_ack;
    logic                  halted;

    // one row per test, byte 0 of the program in the top byte
    logic [127:0] prog_table [n_tests];
    // first expected output in the top byte
    logic [31:0]  exp_table [n_tests];
    int           count_table [n_tests];

    int          test_index;
    logic [31:0] expected;
    int          exp_count;
    int          pass_count;
    int          fail_count;
    int          report_count;
    int          seed;
    int          ack_wait;
    int          t;
    int          a;

    cpu_top cpu_top_i (
        .clk(clk),
        .reset(reset),
        .run(run),
        .load_req(load_req),
        .load_word(load_word),
        .load_ack(load_ack),
        .out_req(out_req),
        .out_value(out_value),
        .out_ack(out_ack),
        .halted(halted)
    );

    cpu_checker cpu_checker_i (
        .clk(clk),
        .reset(reset),
        .out_req(out_req),
        .out_ack(out_ack),
        .out_value(out_value),
        .halted(halted),
        .test_index(test_index),
        .expected(expected),
        .exp_count(exp_count),
        .pass_count(pass_count),
        .fail_count(fail_count),
        .report_count(report_count)
    );

    bind cpu_top cpu_assertions cpu_assertions_i (
        .clk(clk),
        .reset(reset),
        .load_req(load_req),
        .load_ack(load_ack),
        .out_req(out_req),
        .out_value(out_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        // LDI 7, OUT, HLT
        prog_table[0] = 128'h57E0F000_00000000_00000000_00000000;
        exp_table[0] = 32'h07000000;
        count_table[0] = 1;
        // LDA 14, ADD 15, OUT, SUB 13, OUT, HLT with wrap both ways
        prog_table[1] = 128'h1E2FE03D_E0F00000_00000000_0050C864;
        exp_table[1] = 32'h2CDC0000;
        count_table[1] = 2;
        // STA 12 then LDA 12 after clearing acc, then a loaded data byte
        prog_table[2] = 128'h594C501C_E01FE0F0_00000000_000000A5;
        exp_table[2] = 32'h09A50000;
        count_table[2] = 2;
        // countdown loop on SUB, JZ and JMP
        prog_table[3] = 128'h53E03F85_61F00000_00000000_00000001;
        exp_table[3] = 32'h03020100;
        count_table[3] = 3;
        // F0 plus 20 overflows, JC skips the HLT at 4
        prog_table[4] = 128'h1F2E7551_F0E0F000_00000000_000020F0;
        exp_table[4] = 32'h10000000;
        count_table[4] = 1;
        // four OUTs close together under back-pressure, run twice
        prog_table[5] = 128'h54E03FE0_3FE03FE0_F0000000_00000001;
        exp_table[5] = 32'h04030201;
        count_table[5] = 4;
        prog_table[6] = prog_table[5];
        exp_table[6] = exp_table[5];
        count_table[6] = count_table[5];
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    // four-phase write of one program byte
    task automatic load_byte(input int addr, input logic [data_width-1:0] data);
        int cycles;
        load_word.addr = addr[addr_width-1:0];
        load_word.data = data;
        load_req = 1'b1;
        cycles = 0;
        while (!load_ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("load_ack to rise");
        end
        load_req = 1'b0;
        cycles = 0;
        while (load_ack) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("load_ack to fall");
        end
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("halted");
        end
    endtask

    // checker reports once the last handshake is done
    task automatic wait_report(input int n);
        int cycles;
        cycles = 0;
        while (report_count < n) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) stop_on_timeout("the test report");
        end
    endtask

    // ack responder, random delay of 0 to 7 cycles per value
    initial begin
        out_ack = 1'b0;
        ack_wait = -1;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack) begin
                if (ack_wait < 0) ack_wait = $unsigned($random(seed)) % 8;
                if (ack_wait == 0) out_ack = 1'b1;
                else ack_wait--;
            end else if (out_ack && !out_req) begin
                out_ack = 1'b0;
                ack_wait = -1;
            end
        end
    end

    initial begin
        seed = 43878;
        reset = 1'b1;
        run = 1'b0;
        load_req = 1'b0;
        load_word = '0;
        test_index = 0;
        expected = '0;
        exp_count = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (t = 0; t < n_tests; t++) begin
            test_index = t;
            expected = exp_table[t];
            exp_count = count_table[t];
            // whole memory reloaded each row
            for (a = 0; a < mem_depth; a++) begin
                load_byte(a, prog_table[t][127 - 8 * a -: 8]);
            end
            run = 1'b1;
            wait_halted();
            wait_report(t + 1);
            run = 1'b0;
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_tests) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/cpu_pkg.sv
rtl/control_block.sv
rtl/program_counter.sv
rtl/alu.sv
rtl/program_memory.sv
rtl/bus_registers.sv
rtl/output_port.sv
rtl/cpu_top.sv
testbench/cpu_assertions.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== Makefile ====
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
